/* common/tlul_mon_consts.svh */
//////////////////////////////////////////////////////////////////////
// widths and sizes of the TL-UL link seen by the protocol monitor
// include wherever a bus width or the counter width is needed
//////////////////////////////////////////////////////////////////////

`ifndef TLUL_MON_CONSTS_SVH
`define TLUL_MON_CONSTS_SVH

// address and data bus
`define TLUL_AW 32
`define TLUL_DW 32

// byte lanes, one mask bit each
`define TLUL_DBW 4

// a_size / d_size field, log2 of the byte count
`define TLUL_SZW 2

// source ID, one pending-table entry per value
`define TLUL_AIW 4

// saturating violation counter
`define TLUL_VIOL_CNT_W 8

`endif

/* common/tlul_mon_pkg.sv */
//////////////////////////////////////////////////////////////////////
// types shared by the TL-UL monitor blocks
// channel beats, pending-table entry and the violation flag word
//////////////////////////////////////////////////////////////////////

`include "tlul_mon_consts.svh"

package tlul_mon_pkg;

  // request opcodes, TL-UL encoding
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // response opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // one beat on the request channel
  typedef struct packed {
    logic                   a_valid;
    tl_a_op_e               a_opcode;
    logic [2:0]             a_param;
    logic [`TLUL_SZW-1:0]   a_size;
    logic [`TLUL_AIW-1:0]   a_source;
    logic [`TLUL_AW-1:0]    a_address;
    logic [`TLUL_DBW-1:0]   a_mask;
    logic [`TLUL_DW-1:0]    a_data;
  } tl_a_chan_t;

  // one beat on the response channel
  typedef struct packed {
    logic                   d_valid;
    tl_d_op_e               d_opcode;
    logic [2:0]             d_param;
    logic [`TLUL_SZW-1:0]   d_size;
    logic [`TLUL_AIW-1:0]   d_source;
    logic [`TLUL_DW-1:0]    d_data;
    logic                   d_error;
  } tl_d_chan_t;

  // what the monitor remembers about an accepted request
  typedef struct packed {
    logic                   pend;
    tl_a_op_e               opcode;
    logic [`TLUL_SZW-1:0]   size;
    logic [`TLUL_DBW-1:0]   mask;
  } pend_entry_t;

  // one flag per protocol rule, A-channel rules first
  typedef struct packed {
    logic a_opcode_bad;
    logic a_param_bad;
    logic size_mask_bad;
    logic full_mask_bad;
    logic addr_unaligned;
    logic mask_gapped;
    logic src_busy;
    logic d_opcode_bad;
    logic d_param_bad;
    logic d_size_bad;
    logic rsp_orphan;
  } viol_t;

endpackage

/* rtl/tlul_monitor/tlul_monitor_top.sv */
//////////////////////////////////////////////////////////////////////
// TL-UL protocol monitor, top level
// connect to one link, both channels and both readies as inputs
// violations come out as registered pulses, sticky flags and a count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tlul_mon_consts.svh"

module tlul_monitor_top
  import tlul_mon_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // request channel and its ready from the device
  input  tl_a_chan_t                  a_chan_i,
  input  logic                        a_ready_i,
  // response channel and its ready from the host
  input  tl_d_chan_t                  d_chan_i,
  input  logic                        d_ready_i,
  // violation reporting
  output viol_t                       viol_o,
  output viol_t                       sticky_o,
  output logic [`TLUL_VIOL_CNT_W-1:0] count_o,
  output logic                        busy_o
);

  // table lookups
  logic        a_src_pend;
  pend_entry_t d_entry;

  // unregistered flags from the two rule blocks
  viol_t       req_viol;
  viol_t       rsp_viol;

  tlul_pend_table u_pend_table (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .a_chan_i     (a_chan_i),
    .a_ready_i    (a_ready_i),
    .d_chan_i     (d_chan_i),
    .d_ready_i    (d_ready_i),
    .a_src_pend_o (a_src_pend),
    .d_entry_o    (d_entry),
    .busy_o       (busy_o)
  );

  tlul_req_rules u_req_rules (
    .a_chan_i     (a_chan_i),
    .a_src_pend_i (a_src_pend),
    .viol_o       (req_viol)
  );

  tlul_rsp_rules u_rsp_rules (
    .d_chan_i  (d_chan_i),
    .d_entry_i (d_entry),
    .viol_o    (rsp_viol)
  );

  tlul_viol_log u_viol_log (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_viol_i (req_viol),
    .rsp_viol_i (rsp_viol),
    .viol_o     (viol_o),
    .sticky_o   (sticky_o),
    .count_o    (count_o)
  );

endmodule

/* rtl/tlul_monitor/tlul_pend_table.sv */
//////////////////////////////////////////////////////////////////////
// pending-request table of the TL-UL monitor, one entry per source
// written by accepted A beats, released by accepted D beats
// offers a pend lookup at a_source and a full entry at d_source
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tlul_mon_consts.svh"

module tlul_pend_table
  import tlul_mon_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  tl_a_chan_t  a_chan_i,
  input  logic        a_ready_i,
  input  tl_d_chan_t  d_chan_i,
  input  logic        d_ready_i,
  output logic        a_src_pend_o,
  output pend_entry_t d_entry_o,
  output logic        busy_o
);

  localparam int unsigned NUM_SRC = 2 ** `TLUL_AIW;

  // beats taken by the receiver this cycle
  logic a_acc;
  logic d_acc;

  // pend bits are control state, the rest is request payload
  logic [NUM_SRC-1:0]  pend_q;
  tl_a_op_e            opcode_q [NUM_SRC];
  logic [`TLUL_SZW-1:0] size_q  [NUM_SRC];
  logic [`TLUL_DBW-1:0] mask_q  [NUM_SRC];

  assign a_acc = a_chan_i.a_valid & a_ready_i;
  assign d_acc = d_chan_i.d_valid & d_ready_i;

  //////////////////////////////////////////////////////////////////////
  // table update
  //////////////////////////////////////////////////////////////////////

  // clear first, then set, so a request on the source being
  // answered in the same cycle keeps it pending
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= '0;
    end else begin
      if (d_acc) begin
        pend_q[d_chan_i.d_source] <= 1'b0;
      end
      if (a_acc) begin
        pend_q[a_chan_i.a_source] <= 1'b1;
      end
    end
  end

  // opcode, size and mask of the request, needed to judge its response
  always_ff @(posedge clk_i) begin
    if (a_acc) begin
      opcode_q[a_chan_i.a_source] <= a_chan_i.a_opcode;
      size_q[a_chan_i.a_source]   <= a_chan_i.a_size;
      mask_q[a_chan_i.a_source]   <= a_chan_i.a_mask;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // lookups
  //////////////////////////////////////////////////////////////////////

  // duplicate-source check on the request side
  assign a_src_pend_o = pend_q[a_chan_i.a_source];

  // entry the current response is matched against
  assign d_entry_o.pend   = pend_q[d_chan_i.d_source];
  assign d_entry_o.opcode = opcode_q[d_chan_i.d_source];
  assign d_entry_o.size   = size_q[d_chan_i.d_source];
  assign d_entry_o.mask   = mask_q[d_chan_i.d_source];

  // any request still outstanding
  assign busy_o = |pend_q;

endmodule

/* rtl/tlul_monitor/tlul_req_rules.sv */
//////////////////////////////////////////////////////////////////////
// request-channel rule checks of the TL-UL monitor
// purely combinational, flags follow the A beat while a_valid is high
// only the A-side fields of the violation word are ever set here
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tlul_mon_consts.svh"

module tlul_req_rules
  import tlul_mon_pkg::*;
(
  input  tl_a_chan_t a_chan_i,
  input  logic       a_src_pend_i,
  output viol_t      viol_o
);

  // byte count of a transfer, up to 2**(2**SZW - 1)
  localparam int unsigned BYTES_W = 2 ** `TLUL_SZW;
  // enough bits to count every mask lane
  localparam int unsigned ONES_W  = $clog2(`TLUL_DBW + 1);

  // number of set bits in a lane vector
  function automatic logic [ONES_W-1:0] count_ones(input logic [`TLUL_DBW-1:0] vec);
    logic [ONES_W-1:0] n;
    n = '0;
    for (int i = 0; i < `TLUL_DBW; i++) begin
      n = n + ONES_W'(vec[i]);
    end
    return n;
  endfunction

  logic [BYTES_W-1:0]  size_bytes;
  logic [BYTES_W-2:0]  ofs_mask;
  logic [ONES_W-1:0]   mask_ones;
  logic [`TLUL_DBW-1:0] mask_edges;
  logic [ONES_W-1:0]   edge_ones;
  logic                op_legal;

  //////////////////////////////////////////////////////////////////////
  // derived values
  //////////////////////////////////////////////////////////////////////

  assign size_bytes = BYTES_W'(1) << a_chan_i.a_size;

  // low address bits that must be zero for this size
  // the largest size wraps to all ones in the dropped top bit
  assign ofs_mask = size_bytes[BYTES_W-2:0] - 1'b1;

  assign mask_ones = count_ones(a_chan_i.a_mask);

  // a 0/1 transition between neighbouring lanes
  // a contiguous run has at most two of them
  assign mask_edges = a_chan_i.a_mask ^ {a_chan_i.a_mask[`TLUL_DBW-2:0], 1'b0};
  assign edge_ones  = count_ones(mask_edges);

  assign op_legal = a_chan_i.a_opcode inside {Get, PutFullData, PutPartialData};

  //////////////////////////////////////////////////////////////////////
  // rule flags
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    viol_o = '0;
    if (a_chan_i.a_valid) begin
      viol_o.a_opcode_bad = !op_legal;
      viol_o.a_param_bad  = a_chan_i.a_param != '0;
      // reads and partial writes may touch fewer lanes than the size
      viol_o.size_mask_bad = (a_chan_i.a_opcode inside {Get, PutPartialData}) &&
                             (size_bytes < BYTES_W'(mask_ones));
      // full writes must touch exactly size bytes
      viol_o.full_mask_bad = (a_chan_i.a_opcode == PutFullData) &&
                             (size_bytes != BYTES_W'(mask_ones));
      viol_o.addr_unaligned = |(a_chan_i.a_address[BYTES_W-2:0] & ofs_mask);
      viol_o.mask_gapped    = (a_chan_i.a_opcode != PutPartialData) &&
                              (edge_ones > ONES_W'(2));
      // source already has a request outstanding
      viol_o.src_busy = a_src_pend_i;
    end
  end

endmodule

/* rtl/tlul_monitor/tlul_rsp_rules.sv */
//////////////////////////////////////////////////////////////////////
// response-channel rule checks of the TL-UL monitor
// compares the D beat with the table entry of its source
// combinational, only D-side flags, only while d_valid is high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tlul_mon_consts.svh"

module tlul_rsp_rules
  import tlul_mon_pkg::*;
(
  input  tl_d_chan_t  d_chan_i,
  input  pend_entry_t d_entry_i,
  output viol_t       viol_o
);

  // response opcode the stored request calls for
  tl_d_op_e exp_opcode;
  // response has a request to answer
  logic     has_req;

  assign exp_opcode = (d_entry_i.opcode == Get) ? AccessAckData : AccessAck;
  assign has_req    = d_entry_i.pend;

  //////////////////////////////////////////////////////////////////////
  // rule flags
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    viol_o = '0;
    if (d_chan_i.d_valid) begin
      // reserved field
      viol_o.d_param_bad = d_chan_i.d_param != '0;

      // opcode and size only mean something against a live entry
      // an orphan response reports just the missing request
      viol_o.d_opcode_bad = has_req && (d_chan_i.d_opcode != exp_opcode);
      viol_o.d_size_bad   = has_req && (d_chan_i.d_size != d_entry_i.size);

      viol_o.rsp_orphan = !has_req;
    end
  end

endmodule

/* rtl/tlul_monitor/tlul_viol_log.sv */
//////////////////////////////////////////////////////////////////////
// violation log of the TL-UL monitor
// registers the merged rule flags, keeps a sticky copy and counts
// every cycle with at least one violation, saturating at the top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tlul_mon_consts.svh"

module tlul_viol_log
  import tlul_mon_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  viol_t                       req_viol_i,
  input  viol_t                       rsp_viol_i,
  output viol_t                       viol_o,
  output viol_t                       sticky_o,
  output logic [`TLUL_VIOL_CNT_W-1:0] count_o
);

  // the two rule blocks set disjoint fields
  viol_t                       viol_d;
  logic                        any_viol;
  logic                        cnt_full;

  viol_t                       viol_q;
  viol_t                       sticky_q;
  logic [`TLUL_VIOL_CNT_W-1:0] cnt_q;

  assign viol_d   = viol_t'(req_viol_i | rsp_viol_i);
  assign any_viol = |viol_d;
  assign cnt_full = &cnt_q;

  //////////////////////////////////////////////////////////////////////
  // flag registers
  //////////////////////////////////////////////////////////////////////

  // sticky takes the new flags at the same edge as the pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol_q   <= '0;
      sticky_q <= '0;
    end else begin
      viol_q   <= viol_d;
      sticky_q <= viol_t'(sticky_q | viol_d);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // saturating counter
  //////////////////////////////////////////////////////////////////////

  // one step per violating cycle, whatever the number of flags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (any_viol && !cnt_full) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign viol_o   = viol_q;
  assign sticky_o = sticky_q;
  assign count_o  = cnt_q;

endmodule

/* test/tlul_monitor_checker.sv */
//////////////////////////////////////////////////////////////////////
// concurrent assertions on the TL-UL monitor outputs
// bound into the top level, watches the log and its reset behavior
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tlul_mon_consts.svh"

module tlul_monitor_checker
  import tlul_mon_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  viol_t                       viol_i,
  input  viol_t                       sticky_i,
  input  logic [`TLUL_VIOL_CNT_W-1:0] count_i
);

  // number of failed assertions
  int unsigned fail_cnt = 0;

  // first edge out of reset can only show the cleared pulse register
  a_quiet_after_reset: assert property (
    @(posedge clk_i) $rose(rst_ni) |-> (viol_i == '0)
  ) else begin
    $error("viol_o non-zero in the first cycle after reset release");
    fail_cnt++;
  end

  // counter only steps up or holds at its maximum
  a_count_monotonic: assert property (
    @(posedge clk_i) disable iff (!rst_ni) count_i >= $past(count_i)
  ) else begin
    $error("count_o decreased while out of reset");
    fail_cnt++;
  end

  // sticky flags are never cleared outside reset
  a_sticky_kept: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (sticky_i | $past(sticky_i)) == sticky_i
  ) else begin
    $error("sticky_o lost a flag while out of reset");
    fail_cnt++;
  end

endmodule

bind tlul_monitor_top tlul_monitor_checker u_checker (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .viol_i   (viol_o),
  .sticky_i (sticky_o),
  .count_i  (count_o)
);

/* test/tlul_monitor_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench of the TL-UL protocol monitor
// drives both channels, keeps a model of the pending table and
// compares pulses, sticky flags, count and busy every cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tlul_mon_consts.svh"

module tlul_monitor_tb
  import tlul_mon_pkg::*;
();

  localparam int NUM_SRC    = 2 ** `TLUL_AIW;
  localparam int HOLD_N     = 5;
  localparam int SAT_N      = 260;
  // rough beat count of all tests, four cycles each plus margin
  localparam int NUM_BEATS  = 360;
  localparam int TIMEOUT_NS = (NUM_BEATS * 4 + 200) * 8;

  logic                        clk_i;
  logic                        rst_ni;
  tl_a_chan_t                  a_chan;
  logic                        a_ready;
  tl_d_chan_t                  d_chan;
  logic                        d_ready;
  viol_t                       viol;
  viol_t                       sticky;
  logic [`TLUL_VIOL_CNT_W-1:0] count;
  logic                        busy;

  // model of the table and of the log
  pend_entry_t                 model_tbl [NUM_SRC];
  viol_t                       exp_viol;
  viol_t                       exp_sticky;
  logic [`TLUL_VIOL_CNT_W-1:0] exp_cnt;
  logic                        chk_en = 1'b0;

  string       test_name = "init";
  logic [15:0] lfsr_q    = 16'd92;
  int          viol_errs = 0;
  int          cnt_errs  = 0;
  int          busy_errs = 0;

  tlul_monitor_top dut_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .a_chan_i  (a_chan),
    .a_ready_i (a_ready),
    .d_chan_i  (d_chan),
    .d_ready_i (d_ready),
    .viol_o    (viol),
    .sticky_o  (sticky),
    .count_o   (count),
    .busy_o    (busy)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // reference model and compare tasks
  //////////////////////////////////////////////////////////////////////

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 16'hB400 : 16'h0000);
    end
    return v;
  endfunction

  // expected flags for one cycle, from the protocol rules
  function automatic viol_t ref_viol(input tl_a_chan_t a, input logic a_pend,
                                     input tl_d_chan_t d, input pend_entry_t e);
    viol_t v;
    int    ones;
    int    first;
    int    last;
    int    bytes;
    v = '0;
    if (a.a_valid) begin
      ones  = 0;
      first = -1;
      last  = -1;
      for (int i = 0; i < `TLUL_DBW; i++) begin
        if (a.a_mask[i]) begin
          ones++;
          if (first < 0) first = i;
          last = i;
        end
      end
      bytes = 1 << a.a_size;
      v.a_opcode_bad  = !(a.a_opcode inside {Get, PutFullData, PutPartialData});
      v.a_param_bad   = a.a_param != 3'h0;
      v.size_mask_bad = (a.a_opcode == Get || a.a_opcode == PutPartialData) && bytes < ones;
      v.full_mask_bad = (a.a_opcode == PutFullData) && bytes != ones;
      v.addr_unaligned = (a.a_address % bytes) != 0;
      v.mask_gapped   = (a.a_opcode != PutPartialData) && ones != 0 &&
                        (last - first + 1) != ones;
      v.src_busy      = a_pend;
    end
    if (d.d_valid) begin
      v.d_param_bad = d.d_param != 3'h0;
      v.rsp_orphan  = !e.pend;
      // opcode and size are judged only against a live request
      if (e.pend) begin
        v.d_opcode_bad = d.d_opcode != ((e.opcode == Get) ? AccessAckData : AccessAck);
        v.d_size_bad   = d.d_size != e.size;
      end
    end
    return v;
  endfunction

  function automatic logic model_busy();
    logic b;
    b = 1'b0;
    for (int s = 0; s < NUM_SRC; s++) begin
      if (model_tbl[s].pend) b = 1'b1;
    end
    return b;
  endfunction

  task automatic check_viol(input string what, input viol_t exp, input viol_t act);
    if (exp !== act) begin
      viol_errs++;
      $display("error %s: expected %b, actual %b", what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input logic [`TLUL_VIOL_CNT_W-1:0] exp,
                             input logic [`TLUL_VIOL_CNT_W-1:0] act);
    if (exp !== act) begin
      cnt_errs++;
      $display("error %s count: expected %0d, actual %0d", what, exp, act);
    end
  endtask

  task automatic check_busy(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      busy_errs++;
      $display("error %s busy: expected %b, actual %b", what, exp, act);
    end
  endtask

  // model step at each edge, inputs are stable here
  always @(posedge clk_i) begin
    viol_t nxt;
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SRC; s++) model_tbl[s] = '0;
      exp_viol   = '0;
      exp_sticky = '0;
      exp_cnt    = '0;
      chk_en     = 1'b0;
    end else begin
      nxt = ref_viol(a_chan, model_tbl[a_chan.a_source].pend, d_chan,
                     model_tbl[d_chan.d_source]);
      exp_viol   = nxt;
      exp_sticky = viol_t'(exp_sticky | nxt);
      if (nxt != '0 && exp_cnt != '1) exp_cnt++;
      // clear before set, same as the table
      if (d_chan.d_valid && d_ready) model_tbl[d_chan.d_source].pend = 1'b0;
      if (a_chan.a_valid && a_ready) begin
        model_tbl[a_chan.a_source] = '{pend: 1'b1, opcode: a_chan.a_opcode,
                                       size: a_chan.a_size, mask: a_chan.a_mask};
      end
      chk_en = 1'b1;
    end
  end

  // compare in mid cycle, away from both edges
  always @(negedge clk_i) begin
    if (rst_ni && chk_en) begin
      check_viol({test_name, " pulse"}, exp_viol, viol);
      check_viol({test_name, " sticky"}, exp_sticky, sticky);
      check_count(test_name, exp_cnt, count);
      check_busy(test_name, model_busy(), busy);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle();
    a_chan  = '0;
    d_chan  = '0;
    a_ready = 1'b1;
    d_ready = 1'b1;
  endtask

  function automatic tl_a_chan_t make_req(input logic [2:0] op, input logic [2:0] param,
                                          input int size, input int src,
                                          input logic [31:0] addr, input logic [3:0] mask);
    tl_a_chan_t a;
    a           = '0;
    a.a_valid   = 1'b1;
    a.a_opcode  = tl_a_op_e'(op);
    a.a_param   = param;
    a.a_size    = `TLUL_SZW'(size);
    a.a_source  = `TLUL_AIW'(src);
    a.a_address = addr;
    a.a_mask    = mask;
    a.a_data    = addr ^ 32'hA5A5_0000;
    return a;
  endfunction

  function automatic tl_d_chan_t make_rsp(input logic [2:0] op, input logic [2:0] param,
                                          input int size, input int src);
    tl_d_chan_t d;
    d          = '0;
    d.d_valid  = 1'b1;
    d.d_opcode = tl_d_op_e'(op);
    d.d_param  = param;
    d.d_size   = `TLUL_SZW'(size);
    d.d_source = `TLUL_AIW'(src);
    return d;
  endfunction

  // one beat for one edge, flags are visible on return
  task automatic send_req(input tl_a_chan_t a, input logic rdy);
    a_chan  = a;
    a_ready = rdy;
    step();
    idle();
  endtask

  task automatic send_rsp(input tl_d_chan_t d, input logic rdy);
    d_chan  = d;
    d_ready = rdy;
    step();
    idle();
  endtask

  task automatic expect_flags(input viol_t exp);
    check_viol({test_name, " flags"}, exp, viol);
  endtask

  // correct response for whatever the model holds at src
  task automatic answer(input int src);
    tl_d_op_e op;
    op = (model_tbl[src].opcode == Get) ? AccessAckData : AccessAck;
    send_rsp(make_rsp(op, 3'h0, model_tbl[src].size, src), 1'b1);
  endtask

  // random legal request, size up to the bus width, aligned and contiguous
  task automatic legal_req(input int src);
    logic [1:0]  pick;
    int          size;
    logic [31:0] addr;
    tl_a_op_e    op;
    pick = rand_bits(2);
    size = rand_bits(2);
    if (size == 3) size = 2;
    op   = (pick == 1) ? PutFullData : (pick == 2) ? PutPartialData : Get;
    addr = rand_bits(10) & ~((1 << size) - 1);
    send_req(make_req(op, 3'h0, size, src, addr,
                      4'(((1 << (1 << size)) - 1) << addr[1:0])), 1'b1);
  endtask

  task automatic drain();
    for (int s = 0; s < NUM_SRC; s++) begin
      if (model_tbl[s].pend) answer(s);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  initial begin
    viol_t                       exp;
    int                          src;
    logic [`TLUL_VIOL_CNT_W-1:0] cnt_before;
    rst_ni = 1'b0;
    idle();
    repeat (4) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    step();

    // random legal traffic, a pending source gets its answer instead
    test_name = "legal";
    for (int i = 0; i < 40; i++) begin
      src = rand_bits(4);
      if (model_tbl[src].pend) answer(src);
      else legal_req(src);
    end
    drain();
    check_count(test_name, '0, count);
    check_busy(test_name, 1'b0, busy);

    // request shape rules, held off so nothing gets stored
    test_name = "shape";
    exp = '0;
    exp.a_opcode_bad = 1'b1;
    send_req(make_req(3'h7, 3'h0, 2, 0, 32'h0, 4'hf), 1'b0);
    expect_flags(exp);
    exp = '0;
    exp.a_param_bad = 1'b1;
    send_req(make_req(Get, 3'h1, 2, 0, 32'h0, 4'hf), 1'b0);
    expect_flags(exp);
    exp = '0;
    exp.size_mask_bad = 1'b1;
    send_req(make_req(Get, 3'h0, 0, 0, 32'h0, 4'h3), 1'b0);
    expect_flags(exp);
    exp = '0;
    exp.full_mask_bad = 1'b1;
    send_req(make_req(PutFullData, 3'h0, 2, 0, 32'h0, 4'h3), 1'b0);
    expect_flags(exp);
    exp = '0;
    exp.addr_unaligned = 1'b1;
    send_req(make_req(Get, 3'h0, 1, 0, 32'h1, 4'h6), 1'b0);
    expect_flags(exp);
    exp = '0;
    exp.mask_gapped = 1'b1;
    send_req(make_req(Get, 3'h0, 2, 0, 32'h0, 4'h5), 1'b0);
    expect_flags(exp);

    // second request on a pending source, clean again once answered
    test_name = "dup_source";
    send_req(make_req(Get, 3'h0, 2, 9, 32'h40, 4'hf), 1'b1);
    expect_flags('0);
    send_req(make_req(Get, 3'h0, 2, 9, 32'h40, 4'hf), 1'b1);
    exp = '0;
    exp.src_busy = 1'b1;
    expect_flags(exp);
    answer(9);
    expect_flags('0);
    send_req(make_req(Get, 3'h0, 2, 9, 32'h40, 4'hf), 1'b1);
    expect_flags('0);
    answer(9);

    // response rules against a pending Get, held until the good one
    test_name = "rsp_rules";
    send_req(make_req(Get, 3'h0, 2, 3, 32'h80, 4'hf), 1'b1);
    send_rsp(make_rsp(AccessAck, 3'h0, 2, 3), 1'b0);
    exp = '0;
    exp.d_opcode_bad = 1'b1;
    expect_flags(exp);
    send_rsp(make_rsp(AccessAckData, 3'h0, 1, 3), 1'b0);
    exp = '0;
    exp.d_size_bad = 1'b1;
    expect_flags(exp);
    send_rsp(make_rsp(AccessAckData, 3'h1, 2, 3), 1'b0);
    exp = '0;
    exp.d_param_bad = 1'b1;
    expect_flags(exp);
    send_rsp(make_rsp(AccessAckData, 3'h0, 2, 3), 1'b1);
    expect_flags('0);
    send_rsp(make_rsp(AccessAckData, 3'h0, 2, 3), 1'b1);
    exp = '0;
    exp.rsp_orphan = 1'b1;
    expect_flags(exp);

    // unaligned request under back-pressure, one pulse per held cycle
    test_name  = "held";
    cnt_before = count;
    a_chan     = make_req(Get, 3'h0, 1, 4, 32'h1, 4'h6);
    a_ready    = 1'b0;
    exp = '0;
    exp.addr_unaligned = 1'b1;
    repeat (HOLD_N) begin
      step();
      expect_flags(exp);
    end
    idle();
    check_count(test_name, cnt_before + `TLUL_VIOL_CNT_W'(HOLD_N), count);

    // response and new request on one source in the same cycle
    test_name = "overlap";
    send_req(make_req(Get, 3'h0, 2, 5, 32'hc0, 4'hf), 1'b1);
    a_chan = make_req(PutFullData, 3'h0, 2, 5, 32'hc4, 4'hf);
    d_chan = make_rsp(AccessAckData, 3'h0, 2, 5);
    step();
    idle();
    exp = '0;
    exp.src_busy = 1'b1;
    expect_flags(exp);
    check_busy(test_name, 1'b1, busy);
    send_rsp(make_rsp(AccessAck, 3'h0, 2, 5), 1'b1);
    expect_flags('0);
    check_busy(test_name, 1'b0, busy);

    // long run of bad beats on both channels, counter must saturate
    test_name = "saturate";
    a_chan  = make_req(3'h7, 3'h1, 2, 0, 32'h0, 4'hf);
    a_ready = 1'b0;
    d_chan  = make_rsp(AccessAck, 3'h1, 0, 15);
    d_ready = 1'b0;
    repeat (SAT_N) step();
    idle();
    check_count(test_name, '1, count);
    // every rule has fired at least once by now
    check_viol({test_name, " sticky"}, '1, sticky);

    // reset with a pending source and a violation in flight
    test_name = "reset";
    send_req(make_req(Get, 3'h0, 2, 2, 32'h0, 4'hf), 1'b1);
    check_busy(test_name, 1'b1, busy);
    send_req(make_req(3'h7, 3'h0, 2, 0, 32'h0, 4'hf), 1'b0);
    rst_ni = 1'b0;
    repeat (4) step();
    rst_ni = 1'b1;
    check_viol({test_name, " pulse"}, '0, viol);
    check_viol({test_name, " sticky"}, '0, sticky);
    check_count(test_name, '0, count);
    check_busy(test_name, 1'b0, busy);
    step();
    step();

    $display("errors: flags %0d, count %0d, busy %0d, assertions %0d",
             viol_errs, cnt_errs, busy_errs, dut_i.u_checker.fail_cnt);
    if (viol_errs + cnt_errs + busy_errs == 0 && dut_i.u_checker.fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish in %0d ns", TIMEOUT_NS);
    $display("errors: flags %0d, count %0d, busy %0d, assertions %0d",
             viol_errs, cnt_errs, busy_errs, dut_i.u_checker.fail_cnt);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* tlul_monitor.f */
+incdir+common
common/tlul_mon_pkg.sv
rtl/tlul_monitor/tlul_pend_table.sv
rtl/tlul_monitor/tlul_req_rules.sv
rtl/tlul_monitor/tlul_rsp_rules.sv
rtl/tlul_monitor/tlul_viol_log.sv
rtl/tlul_monitor/tlul_monitor_top.sv
test/tlul_monitor_checker.sv
test/tlul_monitor_tb.sv
